// File: logic/realign_pkg.sv
package realign_pkg;

	//////////////////////////////////////////////////
	// stream beat

	// keep[3] marks the first byte in big-endian lane order
	typedef struct packed {
		logic [31:0] data;
		logic [3:0] keep;
		logic last;
	} axis_beat_t;

	//////////////////////////////////////////////////
	// packet statistics

	typedef logic [15:0] pkt_len_t;	// bytes per packet

	//////////////////////////////////////////////////
	// register slice occupancy

	typedef enum logic [1:0] {
		empty = 2'd0,	// nothing held
		one = 2'd1,	// main register only
		two = 2'd2	// main and skid registers
	} slice_state_e;

endpackage

// File: logic/axis_realign.sv
`timescale 1ns/1ps

module axis_realign import realign_pkg::*; #(
	parameter bit input_big_endian = 1'b1,
	parameter bit output_big_endian = 1'b1
) (
	input logic aclk,
	input logic aresetn,

	input axis_beat_t s_beat,
	input logic s_tvalid,
	output logic s_tready,

	output axis_beat_t m_beat,
	output logic m_tvalid,
	input logic m_tready
);

	logic [3:0][7:0] in_byte;	// index 0 is first on the wire
	logic [3:0] in_be;
	logic [1:0] in_off;	// first valid lane
	logic [2:0] in_cnt;	// valid bytes in this beat

	logic [6:0][7:0] hold;	// pending bytes, oldest at index 0
	logic [6:0][7:0] shifted;
	logic [6:0][7:0] hold_next;
	logic [2:0] pend_cnt;
	logic [2:0] base;	// append point after the output beat leaves
	logic [2:0] pend_next;

	logic [3:0] out_be;
	logic [3:0][7:0] out_byte;
	logic out_last;
	logic flush;	// tail of an overflowing packet still pending

	logic in_fire;
	logic out_fire;

	assign s_tready = m_tready && !flush;
	assign in_fire = s_tvalid && s_tready;
	assign out_fire = m_tvalid && m_tready;

	//////////////////////////////////////////////////
	// input lanes

	always_comb
	begin
		if (input_big_endian)
		begin
			in_byte = {<<8{s_beat.data}};
			in_be = {<<{s_beat.keep}};
		end
		else
		begin
			in_byte = s_beat.data;
			in_be = s_beat.keep;
		end
	end

	// keep is one contiguous run, so offset and count describe it fully
	always_comb
	begin
		in_off = 2'd0;
		in_cnt = 3'd0;
		for (int i = 3; i >= 0; i--)
		begin
			if (in_be[i])
				in_off = 2'(i);
		end
		for (int i = 0; i < 4; i++)
			in_cnt = in_cnt + 3'(in_be[i]);
	end

	//////////////////////////////////////////////////
	// pending byte count

	always_comb
	begin
		if (out_fire)
			base = (pend_cnt > 3'd4) ? pend_cnt - 3'd4 : 3'd0;
		else
			base = pend_cnt;
		pend_next = in_fire ? base + in_cnt : base;	// never above 7
	end

	//////////////////////////////////////////////////
	// holding register

	always_comb
	begin : pack_bytes
		logic [2:0] pos;
		logic [1:0] lane;
		for (int j = 0; j < 3; j++)
			shifted[j] = hold[j + 4];	// overflow moves forward
		for (int j = 3; j < 7; j++)
			shifted[j] = hold[j];
		hold_next = out_fire ? shifted : hold;
		for (int j = 0; j < 7; j++)
		begin
			pos = 3'(j) - base;
			lane = in_off + pos[1:0];
			if (in_fire && 3'(j) >= base && pos < in_cnt)
				hold_next[j] = in_byte[lane];
		end
	end

	always_ff @(posedge aclk)
	begin
		hold <= hold_next;
	end

	//////////////////////////////////////////////////
	// output control

	always_ff @(posedge aclk, negedge aresetn)
	begin
		if (!aresetn)
		begin
			pend_cnt <= 3'd0;
			m_tvalid <= 1'b0;
			out_last <= 1'b0;
			flush <= 1'b0;
		end
		else
		begin
			pend_cnt <= pend_next;

			// a stalled beat keeps valid and last as they are
			if (!m_tvalid || out_fire)
			begin
				if (in_fire && s_beat.last)
				begin
					m_tvalid <= 1'b1;
					out_last <= (pend_next <= 3'd4);	// else flush the rest
				end
				else if (flush && pend_next != 3'd0)
				begin
					m_tvalid <= 1'b1;	// short remainder of the packet
					out_last <= 1'b1;
				end
				else
				begin
					m_tvalid <= (pend_next >= 3'd4);
					out_last <= 1'b0;
				end
			end

			if (in_fire && s_beat.last && pend_next > 3'd4)
				flush <= 1'b1;
			else if (out_fire && out_last)
				flush <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// output lanes

	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			out_be[i] = (pend_cnt > 3'(i));
			out_byte[i] = out_be[i] ? hold[i] : 8'h00;	// unused lanes read zero
		end
		m_beat.last = out_last;
		if (output_big_endian)
		begin
			m_beat.data = {<<8{out_byte}};
			m_beat.keep = {<<{out_be}};
		end
		else
		begin
			m_beat.data = out_byte;
			m_beat.keep = out_be;
		end
	end

endmodule

// File: logic/axis_reg_slice.sv
`timescale 1ns/1ps

module axis_reg_slice import realign_pkg::*; (
	input logic aclk,
	input logic aresetn,

	input axis_beat_t s_beat,
	input logic s_tvalid,
	output logic s_tready,

	output axis_beat_t m_beat,
	output logic m_tvalid,
	input logic m_tready
);

	slice_state_e state;
	slice_state_e state_next;
	axis_beat_t skid;	// beat caught while the output stalls

	logic in_fire;
	logic out_fire;

	assign in_fire = s_tvalid && s_tready;
	assign out_fire = m_tvalid && m_tready;

	always_comb
	begin
		state_next = state;
		case (state)
			empty:
				if (in_fire)
					state_next = one;
			one:
				if (in_fire && !out_fire)
					state_next = two;
				else if (!in_fire && out_fire)
					state_next = empty;
			two:
				if (out_fire)
					state_next = one;
			default:
				state_next = empty;
		endcase
	end

	// ready and valid both come straight from flops
	always_ff @(posedge aclk, negedge aresetn)
	begin
		if (!aresetn)
		begin
			state <= empty;
			m_tvalid <= 1'b0;
			s_tready <= 1'b1;
		end
		else
		begin
			state <= state_next;
			m_tvalid <= (state_next != empty);
			s_tready <= (state_next != two);
		end
	end

	always_ff @(posedge aclk)
	begin
		if (state == two && out_fire)
			m_beat <= skid;
		else if (in_fire && (state == empty || out_fire))
			m_beat <= s_beat;
		if (in_fire && state == one && !out_fire)
			skid <= s_beat;
	end

endmodule

// File: logic/pkt_len_monitor.sv
`timescale 1ns/1ps

module pkt_len_monitor import realign_pkg::*; (
	input logic aclk,
	input logic aresetn,

	input axis_beat_t beat,
	input logic tvalid,
	input logic tready,

	output pkt_len_t pkt_len,
	output logic pkt_len_valid
);

	pkt_len_t total;	// bytes seen so far in this packet
	pkt_len_t total_next;
	logic [2:0] beat_cnt;
	logic fire;

	assign fire = tvalid && tready;

	always_comb
	begin
		beat_cnt = 3'd0;
		for (int i = 0; i < 4; i++)
			beat_cnt = beat_cnt + 3'(beat.keep[i]);
		total_next = total + pkt_len_t'(beat_cnt);
	end

	//////////////////////////////////////////////////
	// running total and report pulse

	always_ff @(posedge aclk, negedge aresetn)
	begin
		if (!aresetn)
		begin
			total <= '0;
			pkt_len_valid <= 1'b0;
		end
		else
		begin
			pkt_len_valid <= fire && beat.last;
			if (fire)
				total <= beat.last ? '0 : total_next;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (fire && beat.last)
			pkt_len <= total_next;	// held until the next packet ends
	end

endmodule

// File: logic/realign_top.sv
`timescale 1ns/1ps

module realign_top import realign_pkg::*; #(
	parameter bit input_big_endian = 1'b1,
	parameter bit output_big_endian = 1'b1
) (
	input logic aclk,
	input logic aresetn,

	input axis_beat_t s_beat,
	input logic s_tvalid,
	output logic s_tready,

	output axis_beat_t m_beat,
	output logic m_tvalid,
	input logic m_tready,

	output pkt_len_t pkt_len,
	output logic pkt_len_valid
);

	axis_beat_t core_beat;
	logic core_tvalid;
	logic core_tready;	// registered in the slice

	axis_realign #(
		.input_big_endian(input_big_endian),
		.output_big_endian(output_big_endian)
	) realign_i (
		.aclk(aclk),
		.aresetn(aresetn),
		.s_beat(s_beat),
		.s_tvalid(s_tvalid),
		.s_tready(s_tready),
		.m_beat(core_beat),
		.m_tvalid(core_tvalid),
		.m_tready(core_tready)
	);

	axis_reg_slice slice_i (
		.aclk(aclk),
		.aresetn(aresetn),
		.s_beat(core_beat),
		.s_tvalid(core_tvalid),
		.s_tready(core_tready),
		.m_beat(m_beat),
		.m_tvalid(m_tvalid),
		.m_tready(m_tready)
	);

	// watches the external output, drives nothing on the stream
	pkt_len_monitor monitor_i (
		.aclk(aclk),
		.aresetn(aresetn),
		.beat(m_beat),
		.tvalid(m_tvalid),
		.tready(m_tready),
		.pkt_len(pkt_len),
		.pkt_len_valid(pkt_len_valid)
	);

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int half_period = 50,
	parameter int reset_cycles = 16
) (
	output logic aclk,
	output logic aresetn
);

	initial
	begin
		aclk = 1'b0;
		forever #(half_period) aclk = ~aclk;
	end

	initial
	begin
		aresetn = 1'b0;
		repeat (reset_cycles) @(posedge aclk);
		#10;
		aresetn = 1'b1;	// released on the drive point
	end

endmodule

// File: verif/realign_properties.sv
`timescale 1ns/1ps

module realign_properties import realign_pkg::*; #(
	parameter bit check_state = 1'b0
) (
	input logic aclk,
	input logic aresetn,
	input axis_beat_t s_beat,
	input logic s_tvalid,
	input logic s_tready,
	input axis_beat_t m_beat,
	input logic m_tvalid,
	input logic m_tready,
	input slice_state_e state
);

	int fail_cnt = 0;	// read by the testbench at the end
	logic [1:0] occ;	// beats accepted and not yet sent on

	always_ff @(posedge aclk, negedge aresetn)
	begin
		if (!aresetn)
			occ <= 2'd0;
		else
			occ <= occ + 2'(s_tvalid && s_tready) - 2'(m_tvalid && m_tready);
	end

	keep_legal: assert property (@(posedge aclk) disable iff (!aresetn)
		s_tvalid |-> s_beat.keep inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011,
			4'b0110, 4'b1100, 4'b0111, 4'b1110, 4'b1111})
	else
	begin
		fail_cnt++;
		$error("input keep %h is zero or not contiguous", s_beat.keep);
	end

	input_stable: assert property (@(posedge aclk) disable iff (!aresetn)
		s_tvalid && !s_tready |=> s_tvalid && $stable(s_beat))
	else
	begin
		fail_cnt++;
		$error("input beat changed while stalled");
	end

	// valid only with a beat held, never while empty
	valid_not_empty: assert property (@(posedge aclk) disable iff (!aresetn || !check_state)
		state == slice_state_e'(occ) && m_tvalid == (occ != 2'd0))
	else
	begin
		fail_cnt++;
		$error("slice state %0d and valid %b do not match %0d beats held",
			state, m_tvalid, occ);
	end

	full_keep: assert property (@(posedge aclk) disable iff (!aresetn)
		m_tvalid && !m_beat.last |-> m_beat.keep == 4'hf)
	else
	begin
		fail_cnt++;
		$error("output beat without last has keep %h", m_beat.keep);
	end

endmodule

bind axis_realign realign_properties #(.check_state(1'b0)) realign_props_i (
	.aclk(aclk), .aresetn(aresetn),
	.s_beat(s_beat), .s_tvalid(s_tvalid), .s_tready(s_tready),
	.m_beat(m_beat), .m_tvalid(m_tvalid), .m_tready(m_tready),
	.state(empty)	// no occupancy state in the core
);

bind axis_reg_slice realign_properties #(.check_state(1'b1)) slice_props_i (
	.aclk(aclk), .aresetn(aresetn),
	.s_beat(s_beat), .s_tvalid(s_tvalid), .s_tready(s_tready),
	.m_beat(m_beat), .m_tvalid(m_tvalid), .m_tready(m_tready),
	.state(state)
);

// File: verif/tb_realign.sv
`timescale 1ns/1ps

module tb_realign import realign_pkg::*;;

	logic aclk;
	logic aresetn;
	axis_beat_t s_beat;
	logic s_tvalid;
	logic s_tready;
	axis_beat_t m_beat;
	logic m_tvalid;
	logic m_tready;
	pkt_len_t pkt_len;
	logic pkt_len_valid;

	axis_beat_t pkt_beats[$];	// packet being built
	axis_beat_t exp_beats[$];
	pkt_len_t exp_lens[$];
	logic [15:0] lfsr_state = 16'd39414;
	logic gap_en = 1'b0;
	logic stall_en = 1'b0;
	int err_cnt = 0;
	int err_at_start = 0;
	int test_cnt = 0;
	int beats_sent = 0;
	int packets_sent = 0;
	int beats_checked = 0;
	int len_pulses = 0;

	tb_clock_gen #(.half_period(50), .reset_cycles(16)) clock_i (
		.aclk(aclk),
		.aresetn(aresetn)
	);

	realign_top #(.input_big_endian(1'b1), .output_big_endian(1'b1)) dut_i (
		.aclk(aclk), .aresetn(aresetn),
		.s_beat(s_beat), .s_tvalid(s_tvalid), .s_tready(s_tready),
		.m_beat(m_beat), .m_tvalid(m_tvalid), .m_tready(m_tready),
		.pkt_len(pkt_len), .pkt_len_valid(pkt_len_valid)
	);

	//////////////////////////////////////////////////
	// random source and reference model

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	// kept bytes in wire order, cut into left-justified beats of four
	function automatic void model_packet();
		logic [7:0] bytes[$];
		axis_beat_t b;
		int n;
		for (int i = 0; i < pkt_beats.size(); i++)
			for (int k = 3; k >= 0; k--)
				if (pkt_beats[i].keep[k])
					bytes.push_back(pkt_beats[i].data[8 * k +: 8]);
		exp_lens.push_back(pkt_len_t'(bytes.size()));
		while (bytes.size() > 0)
		begin
			b = '0;
			n = (bytes.size() > 4) ? 4 : bytes.size();
			for (int k = 0; k < n; k++)
			begin
				b.data[8 * (3 - k) +: 8] = bytes.pop_front();
				b.keep[3 - k] = 1'b1;
			end
			b.last = (bytes.size() == 0);
			exp_beats.push_back(b);
		end
	endfunction

	//////////////////////////////////////////////////
	// compare tasks and compare process

	task automatic compare_beat(input axis_beat_t exp, input axis_beat_t got);
		logic [31:0] mask;
		for (int i = 0; i < 4; i++)
			mask[8 * i +: 8] = {8{exp.keep[i]}};	// unkept lanes carry no data
		beats_checked++;
		if ((exp.data & mask) !== (got.data & mask))
		begin
			err_cnt++;
			$display("[ERROR] m_beat.data expected %h got %h", exp.data & mask, got.data & mask);
		end
		if (exp.keep !== got.keep)
		begin
			err_cnt++;
			$display("[ERROR] m_beat.keep expected %h got %h", exp.keep, got.keep);
		end
		if (exp.last !== got.last)
		begin
			err_cnt++;
			$display("[ERROR] m_beat.last expected %h got %h", exp.last, got.last);
		end
	endtask

	task automatic compare_len(input pkt_len_t exp, input pkt_len_t got);
		if (exp !== got)
		begin
			err_cnt++;
			$display("[ERROR] pkt_len expected %h got %h", exp, got);
		end
	endtask

	always @(negedge aclk)
	begin
		if (aresetn)
		begin
			if (m_tvalid && m_tready)
			begin
				if (exp_beats.size() == 0)
				begin
					err_cnt++;
					$display("an output beat left the DUT when none was expected");
				end
				else
					compare_beat(exp_beats.pop_front(), m_beat);
			end
			if (pkt_len_valid)
			begin
				len_pulses++;
				if (exp_lens.size() == 0)
				begin
					err_cnt++;
					$display("pkt_len_valid pulsed with no packet outstanding");
				end
				else
					compare_len(exp_lens.pop_front(), pkt_len);
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus

	initial
	begin
		logic ready_next;
		m_tready = 1'b1;
		forever
		begin
			@(posedge aclk);
			ready_next = stall_en ? (rand_bits(2) != 0) : 1'b1;	// ready 3 of 4 cycles
			#10;
			m_tready = ready_next;
		end
	end

	// entered and left 10 ns after a rising edge
	task automatic send_beat(input axis_beat_t b);
		logic ready;
		while (gap_en && rand_bits(1))
		begin
			s_tvalid = 1'b0;
			@(posedge aclk);
			#10;
		end
		s_beat = b;
		s_tvalid = 1'b1;
		beats_sent++;
		ready = s_tready;	// registered, stable until the next edge
		@(posedge aclk);
		while (!ready)
		begin
			#10;
			ready = s_tready;
			@(posedge aclk);
		end
		#10;
		s_tvalid = 1'b0;
	endtask

	task automatic run_packet();
		model_packet();
		for (int i = 0; i < pkt_beats.size(); i++)
			send_beat(pkt_beats[i]);
		packets_sent++;
	endtask

	task automatic send_packet(input int off, input int len);
		axis_beat_t b;
		int pos;
		int left;
		int n;
		pkt_beats.delete();
		pos = off;
		left = len;
		while (left > 0)
		begin
			n = (4 - pos < left) ? 4 - pos : left;
			b.data = rand_bits(32);
			b.keep = '0;
			for (int k = pos; k < pos + n; k++)
				b.keep[3 - k] = 1'b1;
			left -= n;
			b.last = (left == 0);
			pkt_beats.push_back(b);
			pos = 0;
		end
		run_packet();
	endtask

	// any contiguous run in every beat, middle beats included
	task automatic send_random_packet(input int nbeats);
		axis_beat_t b;
		int off;
		int cnt;
		pkt_beats.delete();
		for (int i = 0; i < nbeats; i++)
		begin
			off = rand_bits(2);
			cnt = 1 + rand_bits(2) % (4 - off);
			b.data = rand_bits(32);
			b.keep = '0;
			for (int k = off; k < off + cnt; k++)
				b.keep[3 - k] = 1'b1;
			b.last = (i == nbeats - 1);
			pkt_beats.push_back(b);
		end
		run_packet();
	endtask

	task automatic finish_test(input string name);
		while (exp_beats.size() != 0 || exp_lens.size() != 0)
			@(posedge aclk);
		repeat (2) @(posedge aclk);
		#10;
		if (len_pulses != packets_sent)
		begin
			err_cnt++;
			$display("%0d packets sent but %0d length pulses seen", packets_sent, len_pulses);
		end
		test_cnt++;
		if (err_cnt == err_at_start)
			$display("test %0d %s: ok", test_cnt, name);
		else
			$display("test %0d %s: failed, %0d errors", test_cnt, name, err_cnt - err_at_start);
		err_at_start = err_cnt;
	endtask

	initial
	begin : main
		s_beat = '0;
		s_tvalid = 1'b0;
		wait (aresetn === 1'b1);
		@(posedge aclk);
		#10;

		for (int n = 1; n <= 4; n++)
			send_packet(0, 8 + n);
		for (int n = 1; n <= 4; n++)
			send_packet(0, n);
		finish_test("aligned packets");

		for (int off = 1; off <= 3; off++)
			for (int tail = 1; tail <= 3; tail++)
				send_packet(off, (4 - off) + 4 + tail);
		finish_test("offset start and short end");

		for (int off = 1; off <= 3; off++)
		begin
			send_packet(off, 8 - off);	// 5 to 7 bytes pending at last
			send_packet(0, 2);
		end
		send_packet(3, 8);
		send_packet(2, 1);
		finish_test("overflowing tails");

		gap_en = 1'b1;
		stall_en = 1'b1;
		for (int p = 0; p < 16; p++)
			send_random_packet(1 + rand_bits(2));
		finish_test("random stalls and gaps");

		gap_en = 1'b0;
		for (int len = 1; len <= 12; len++)
			send_packet(rand_bits(2), len);
		finish_test("packet lengths");

		stall_en = 1'b0;
		for (int off = 0; off < 4; off++)
			send_packet(off, 1);
		finish_test("single byte packets");

		err_cnt += dut_i.realign_i.realign_props_i.fail_cnt;
		err_cnt += dut_i.slice_i.slice_props_i.fail_cnt;
		$display("tests %0d, beats checked %0d, lengths checked %0d, errors %0d",
			test_cnt, beats_checked, len_pulses, err_cnt);
		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	//////////////////////////////////////////////////
	// watchdog

	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= (beats_sent + 16) * 40)	// budget grows with each beat sent
		begin
			@(posedge aclk);
			cycles++;
		end
		$display("timeout: the output stalled after %0d beats sent in %0d cycles",
			beats_sent, cycles);
		$display("Errors found");
		$finish;
	end

endmodule

// File: sources.f
logic/realign_pkg.sv
logic/axis_realign.sv
logic/axis_reg_slice.sv
logic/pkt_len_monitor.sv
logic/realign_top.sv
verif/tb_clock_gen.sv
verif/realign_properties.sv
verif/tb_realign.sv
